// File: idPkg.sv
// Shared decode types; fixed 32 x 32-bit register file, MIPS-I encodings only, no coprocessor ops.
package idPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [4:0]  regAddrT;                  // Register index.
	typedef logic [31:0] wordT;                     // Data word.

	// Opcode field, instr[31:26].
	localparam logic [5:0] opRType = 6'h00;         // Special, uses funct.
	localparam logic [5:0] opLw    = 6'h23;         // Load word.
	localparam logic [5:0] opSw    = 6'h2B;         // Store word.
	localparam logic [5:0] opBeq   = 6'h04;         // Branch if equal.
	localparam logic [5:0] opAddi  = 6'h08;         // Add immediate.

	// Funct field, instr[5:0], R-type only.
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2A;

	// ALU operation class. Zero sits at 2'b00 so a bubble or an
	// illegal op carries an all-zero control word.
	typedef enum logic [1:0] {
		aluZero  = 2'b00,                           // Illegal, no operation.
		aluAdd   = 2'b01,                           // Address calc and addi.
		aluSub   = 2'b10,                           // Compare for beq.
		aluFunct = 2'b11                            // Execute decodes funct.
	} aluOpT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic  regDst;                              // Dest is rd, else rt.
		logic  aluSrc;                              // Operand B is immediate.
		logic  memRead;                             // Load.
		logic  memWrite;                            // Store.
		logic  memToReg;                            // Writeback from memory.
		logic  regWrite;                            // Writes a register.
		logic  branch;                              // Conditional branch.
		aluOpT aluOp;                               // ALU class.
		logic  illegal;                             // Unsupported encoding.
	} ctrlBundleT;                                  // 10 bits.

	typedef struct packed {
		logic    regWrite;                          // Write enable from WB.
		regAddrT writeReg;                          // Destination register.
		wordT    writeData;                         // Result being retired.
	} wbBusT;                                       // 38 bits.

	typedef struct packed {
		logic       valid;                          // Real instruction, not bubble.
		ctrlBundleT ctrl;
		wordT       pcPlus4;
		wordT       readData1;                      // rs operand.
		wordT       readData2;                      // rt operand.
		wordT       signExtImm;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    rd;
		logic [5:0] funct;
	} idExBundleT;                                  // 160 bits.

endpackage

// File: regFile.sv
// 32 x 32 register file; register 0 reads zero, bypass selects come from hazardUnit, reset clears all.
`timescale 1ns/1ps

module regFile import idPkg::*; (
	input  logic       Clk,
	input  logic       rstN,
	input  regAddrT    readAddr1,                   // rs.
	input  regAddrT    readAddr2,                   // rt.
	input  wbBusT      wb,                          // Writeback port.
	input  logic [1:0] bypassSel,                   // Bit 0 port 1, bit 1 port 2.
	output wordT       readData1,
	output wordT       readData2
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	wordT regs [0:31];                              // Entry 0 never written.
	logic wrEn;                                     // Qualified write strobe.

	assign wrEn = wb.regWrite && (wb.writeReg != '0); // No writes to $zero.

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;                      // Clean state, no preload.
			end
		end else if (wrEn) begin
			regs[wb.writeReg] <= wb.writeData;      // Visible next cycle.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Zero check wins over bypass, so a WB write aimed at $zero
	// cannot leak through the pass-through path.
	always_comb begin
		if (readAddr1 == '0) begin
			readData1 = '0;                         // Hard-wired zero.
		end else if (bypassSel[0]) begin
			readData1 = wb.writeData;               // Same-cycle WB.
		end else begin
			readData1 = regs[readAddr1];
		end
	end

	always_comb begin
		if (readAddr2 == '0) begin
			readData2 = '0;                         // Hard-wired zero.
		end else if (bypassSel[1]) begin
			readData2 = wb.writeData;               // Same-cycle WB.
		end else begin
			readData2 = regs[readAddr2];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Holds even when WB targets $zero with bypass raised by hazardUnit.
	zeroReadsZero: assert property (@(posedge Clk) disable iff (!rstN)
		((readAddr1 == '0) |-> (readData1 == '0)) and
		((readAddr2 == '0) |-> (readData2 == '0)))
		else $error("register zero read back nonzero");

endmodule

// File: instrDecode.sv
// Decodes R-type add/sub/and/or/slt, lw, sw, beq, addi; anything else is a flagged no-op.
`timescale 1ns/1ps

module instrDecode import idPkg::*; (
	input  wordT       instr,
	output regAddrT    rs,
	output regAddrT    rt,
	output regAddrT    rd,
	output logic [5:0] funct,
	output wordT       signExtImm,
	output ctrlBundleT ctrl
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field split
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic [5:0] opcode;                             // instr[31:26].
	logic       functOk;                            // Supported R-type funct.

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];                     // Passed on even for I-type.

	assign signExtImm = {{16{instr[15]}}, instr[15:0]}; // Replicate bit 15.

	always_comb begin
		case (funct)
			fnAdd, fnSub, fnAnd, fnOr, fnSlt: functOk = 1'b1;
			default:                          functOk = 1'b0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ctrl = '0;                                  // All-zero default.
		case (opcode)
			opRType: begin
				if (functOk) begin
					ctrl.regDst   = 1'b1;           // Write rd.
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = aluFunct;
				end else begin
					ctrl.illegal  = 1'b1;           // Unknown funct.
				end
			end
			opLw: begin
				ctrl.aluSrc   = 1'b1;               // Base + offset.
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;               // Into rt.
				ctrl.aluOp    = aluAdd;
			end
			opSw: begin
				ctrl.aluSrc   = 1'b1;               // Base + offset.
				ctrl.memWrite = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opBeq: begin
				ctrl.branch   = 1'b1;               // Resolved downstream.
				ctrl.aluOp    = aluSub;
			end
			opAddi: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;               // Into rt.
				ctrl.aluOp    = aluAdd;
			end
			default: begin
				ctrl.illegal  = 1'b1;               // Unsupported opcode.
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Across the whole table, no encoding may both load and store.
	noLoadStore: assert final (!(ctrl.memRead && ctrl.memWrite))
		else $error("decode set memRead and memWrite together");

endmodule

// File: hazardUnit.sv
// Bypass selects for same-cycle WB and load-use stall; rt is compared even when unused by the op.
`timescale 1ns/1ps

module hazardUnit import idPkg::*; (
	input  regAddrT    rs,
	input  regAddrT    rt,
	input  wbBusT      wb,                          // Writeback this cycle.
	input  logic       exMemRead,                   // Load sitting in EX.
	input  regAddrT    exWriteReg,                  // Its destination.
	output logic [1:0] bypassSel,                   // To regFile.
	output logic       stall                        // To fetch and ID/EX.
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Writeback pass-through
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// No zero test here. regFile masks address 0 itself.
	logic wbHitRs;
	logic wbHitRt;

	assign wbHitRs = wb.regWrite && (wb.writeReg == rs);
	assign wbHitRt = wb.regWrite && (wb.writeReg == rt);

	assign bypassSel = {wbHitRt, wbHitRs};          // Bit 1 rt, bit 0 rs.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load-use
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Loaded data is not ready until MEM, and only the WB pass-through
	// exists, so any consumer of a load in EX waits one cycle.
	logic exLoadLive;                               // Load with real destination.
	logic exHitRs;
	logic exHitRt;

	assign exLoadLive = exMemRead && (exWriteReg != '0); // $zero needs no wait.
	assign exHitRs    = (exWriteReg == rs);
	assign exHitRt    = (exWriteReg == rt);

	assign stall = exLoadLive && (exHitRs || exHitRt); // Pure function of inputs.

endmodule

// File: idExReg.sv
// ID/EX pipeline register; no back-pressure from EX, a held or invalid slot becomes a bubble.
`timescale 1ns/1ps

module idExReg import idPkg::*; (
	input  logic       Clk,
	input  logic       rstN,
	input  logic       ifValid,                     // IF/ID slot holds a real instr.
	input  logic       stall,                       // Load-use from hazardUnit.
	input  idExBundleT next,                        // Assembled decode result.
	output idExBundleT idEx
);

	logic load;                                     // Advance a real instruction.

	assign load = ifValid && !stall;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;                             // Valid and ctrl cleared.
		end else begin
			idEx <= next;                           // Payload always follows.
			if (load) begin
				idEx.valid <= 1'b1;
			end else begin
				idEx.valid <= 1'b0;                 // Bubble.
				idEx.ctrl  <= '0;                   // Nothing downstream fires.
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// A bubble must not change architectural state in later stages.
	bubbleInert: assert property (@(posedge Clk) disable iff (!rstN)
		!idEx.valid |-> (!idEx.ctrl.regWrite && !idEx.ctrl.memWrite))
		else $error("bubble carries a write enable");

endmodule

// File: idStage.sv
// Decode stage top; IF/ID must hold instr, pcPlus4 and ifValid while stall is high.
`timescale 1ns/1ps

module idStage import idPkg::*; (
	input  logic       Clk,
	input  logic       rstN,
	input  wordT       instr,                       // From IF/ID.
	input  wordT       pcPlus4,                     // From IF/ID.
	input  logic       ifValid,                     // From IF/ID.
	input  wbBusT      wb,                          // From writeback.
	input  logic       exMemRead,                   // From execute.
	input  regAddrT    exWriteReg,                  // From execute.
	output idExBundleT idEx,                        // To execute.
	output logic       stall                        // To fetch.
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal nets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	regAddrT    rs;
	regAddrT    rt;
	regAddrT    rd;
	logic [5:0] funct;
	wordT       signExtImm;
	ctrlBundleT ctrl;
	logic [1:0] bypassSel;                          // WB pass-through per port.
	wordT       readData1;
	wordT       readData2;
	idExBundleT next;                               // D side of ID/EX.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Blocks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	instrDecode i_instrDecode (
		.instr      (instr),
		.rs         (rs),
		.rt         (rt),
		.rd         (rd),
		.funct      (funct),
		.signExtImm (signExtImm),
		.ctrl       (ctrl)
	);

	hazardUnit i_hazardUnit (
		.rs         (rs),
		.rt         (rt),
		.wb         (wb),
		.exMemRead  (exMemRead),
		.exWriteReg (exWriteReg),
		.bypassSel  (bypassSel),
		.stall      (stall)
	);

	regFile i_regFile (
		.Clk       (Clk),
		.rstN      (rstN),
		.readAddr1 (rs),
		.readAddr2 (rt),
		.wb        (wb),
		.bypassSel (bypassSel),
		.readData1 (readData1),
		.readData2 (readData2)
	);

	// Bundle assembly. idExReg decides valid and bubbling.
	assign next = '{valid: ifValid, ctrl: ctrl, pcPlus4: pcPlus4,
		readData1: readData1, readData2: readData2, signExtImm: signExtImm,
		rs: rs, rt: rt, rd: rd, funct: funct};

	idExReg i_idExReg (
		.Clk     (Clk),
		.rstN    (rstN),
		.ifValid (ifValid),
		.stall   (stall),
		.next    (next),
		.idEx    (idEx)
	);

endmodule

// File: idStageModel.svh
// Reference model, included inside a module that imports idPkg; shadow registers start cleared.
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

wordT shadowRegs [0:31];                            // Architectural copy.

function automatic void clearShadow();
	for (int i = 0; i < 32; i++) begin
		shadowRegs[i] = '0;
	end
endfunction

// Write rule at the rising edge. Register zero stays zero.
function automatic void applyWriteback(input wbBusT w);
	if (w.regWrite && w.writeReg != 5'd0) begin
		shadowRegs[w.writeReg] = w.writeData;
	end
endfunction

function automatic wordT readOperand(input regAddrT a, input wbBusT w);
	if (a == 5'd0) begin
		return '0;                                  // Hard zero first.
	end
	if (w.regWrite && w.writeReg == a) begin
		return w.writeData;                         // Same-cycle writeback.
	end
	return shadowRegs[a];
endfunction

function automatic logic loadUseStall(input wordT ins, input logic memRd, input regAddrT dst);
	return memRd && dst != 5'd0 && (dst == ins[25:21] || dst == ins[20:16]);
endfunction

// Field order: regDst aluSrc memRead memWrite memToReg regWrite branch aluOp illegal.
function automatic ctrlBundleT decodeTable(input wordT ins);
	ctrlBundleT c;
	c = '0;
	case (ins[31:26])
		opRType: begin
			if (ins[5:0] inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt}) begin
				c = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, aluFunct, 1'b0};
			end else begin
				c.illegal = 1'b1;                   // Unknown funct.
			end
		end
		opLw:    c = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, aluAdd, 1'b0};
		opSw:    c = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, aluAdd, 1'b0};
		opBeq:   c = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, aluSub, 1'b0};
		opAddi:  c = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, aluAdd, 1'b0};
		default: c.illegal = 1'b1;                  // Unsupported opcode.
	endcase
	return c;
endfunction

// ID/EX contents expected one edge after these inputs.
function automatic idExBundleT expectedIdEx(input wordT ins, input wordT pc, input logic vld,
	input wbBusT w, input logic memRd, input regAddrT dst);
	idExBundleT e;
	e.valid      = vld && !loadUseStall(ins, memRd, dst);
	e.ctrl       = e.valid ? decodeTable(ins) : '0;
	e.pcPlus4    = pc;
	e.readData1  = readOperand(ins[25:21], w);
	e.readData2  = readOperand(ins[20:16], w);
	e.signExtImm = 32'($signed(ins[15:0]));          // Signed widening of the low half.
	e.rs         = ins[25:21];
	e.rt         = ins[20:16];
	e.rd         = ins[15:11];
	e.funct      = ins[5:0];
	return e;
endfunction

`endif

// File: idStageTb.sv
// Self-checking testbench for idStage; xorshift seed 6299, payload checked only on valid slots.
`timescale 1ns/1ps

module idStageTb import idPkg::*; ();

	logic       Clk;
	logic       rstN;
	wordT       instr;
	wordT       pcPlus4;
	logic       ifValid;
	wbBusT      wb;
	logic       exMemRead;
	regAddrT    exWriteReg;
	idExBundleT idEx;
	logic       stall;

	logic [31:0] rngState;                          // Xorshift state.
	wordT        pcCount;                           // Fetch PC, advances on accept.
	int          errCount;
	int          checkCount;
	bit          timedOut;

	`include "idStageModel.svh"

	idStage i_idStage (.*);

	initial begin
		Clk = 1'b0;
		forever begin
			#50 Clk = ~Clk;                         // 100 ns period.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic regAddrT randReg();
		logic [31:0] r;
		r = xorshift();
		return r[4:0];
	endfunction

	function automatic wbBusT makeWb(input logic we, input regAddrT r);
		return '{regWrite: we, writeReg: r, writeData: xorshift()};
	endfunction

	function automatic wordT rType(input regAddrT a, input regAddrT b, input regAddrT d,
		input logic [5:0] fn);
		return {opRType, a, b, d, 5'd0, fn};
	endfunction

	// Supported opcodes and functs, plus random and illegal encodings.
	function automatic wordT randomInstr();
		wordT r;
		r = xorshift();
		case (xorshift() % 8)
			0, 1: begin
				r[31:26] = opRType;
				case (xorshift() % 5)
					0: r[5:0] = fnAdd;
					1: r[5:0] = fnSub;
					2: r[5:0] = fnAnd;
					3: r[5:0] = fnOr;
					default: r[5:0] = fnSlt;
				endcase
			end
			2: r[31:26] = opRType;                  // Random funct, mostly illegal.
			3: r[31:26] = opLw;
			4: r[31:26] = opSw;
			5: r[31:26] = opBeq;
			6: r[31:26] = opAddi;
			default: ;                              // Raw word, mostly illegal opcode.
		endcase
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	// Drive at the falling edge, check stall, then ID/EX at the next falling edge.
	task automatic stepCycle(input wordT ins, input logic vld, input wbBusT w,
		input logic memRd, input regAddrT dst);
		idExBundleT exp;
		instr      = ins;
		pcPlus4    = pcCount;
		ifValid    = vld;
		wb         = w;
		exMemRead  = memRd;
		exWriteReg = dst;
		exp = expectedIdEx(ins, pcCount, vld, w, memRd, dst);
		#5;
		checkHex("stall", 32'(stall), 32'(loadUseStall(ins, memRd, dst)));
		@(posedge Clk);
		applyWriteback(w);                          // Shadow follows the edge.
		if (exp.valid) begin
			pcCount += 32'd4;
		end
		@(negedge Clk);
		checkHex("idEx.valid", 32'(idEx.valid), 32'(exp.valid));
		checkHex("idEx.ctrl", 32'(idEx.ctrl), 32'(exp.ctrl));
		if (exp.valid) begin
			checkHex("idEx.pcPlus4", idEx.pcPlus4, exp.pcPlus4);
			checkHex("idEx.readData1", idEx.readData1, exp.readData1);
			checkHex("idEx.readData2", idEx.readData2, exp.readData2);
			checkHex("idEx.signExtImm", idEx.signExtImm, exp.signExtImm);
			checkHex("idEx.rs rt rd funct", 32'({idEx.rs, idEx.rt, idEx.rd, idEx.funct}),
				32'({exp.rs, exp.rt, exp.rd, exp.funct}));
		end
	endtask

	task automatic reportTest(input int num, input string name, input int startErr);
		$display("test %0d %s: %s", num, name,
			(errCount == startErr && !timedOut) ? "passed" : "failed");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic runTests();
		int          startErr;
		int          holdFor;
		int          seen;
		wordT        ins;
		regAddrT     r;
		regAddrT     a;
		logic [31:0] sel;
		startErr = errCount;                        // Reset state, then reads of zero.
		checkHex("idEx.valid", 32'(idEx.valid), 32'd0);
		checkHex("idEx.ctrl", 32'(idEx.ctrl), 32'd0);
		checkHex("stall", 32'(stall), 32'd0);
		for (int i = 0; i < 16; i++) begin
			stepCycle(rType(randReg(), randReg(), randReg(), fnAdd), 1'b1, makeWb(1'b0, 5'd0),
				1'b0, 5'd0);
		end
		reportTest(1, "reset state", startErr);
		startErr = errCount;                        // Writes first, reads later.
		for (int i = 0; i < 40; i++) begin
			r = (i % 8 == 0) ? 5'd0 : randReg();    // Some writes aim at $zero.
			stepCycle(randomInstr(), 1'b0, makeWb(1'b1, r), 1'b0, 5'd0);
		end
		for (int i = 0; i < 40; i++) begin
			a = (i % 10 == 0) ? 5'd0 : randReg();
			stepCycle(rType(a, randReg(), randReg(), fnOr), 1'b1, makeWb(1'b0, 5'd0), 1'b0, 5'd0);
		end
		reportTest(2, "write then read", startErr);
		startErr = errCount;
		for (int i = 0; i < 30; i++) begin
			r = randReg();
			sel = xorshift();
			a = sel[0] ? r : randReg();
			ins = rType(a, (sel[1] || !sel[0]) ? r : randReg(), randReg(), fnSub);
			stepCycle(ins, 1'b1, makeWb(sel[2] | sel[3], r), 1'b0, 5'd0); // Mostly writing.
		end
		reportTest(3, "pass-through", startErr);
		startErr = errCount;
		for (int i = 0; i < 60; i++) begin
			stepCycle(randomInstr(), 1'b1, makeWb(1'b0, 5'd0), 1'b0, 5'd0);
		end
		reportTest(4, "decode", startErr);
		startErr = errCount;
		for (int i = 0; i < 30; i++) begin
			ins = randomInstr();
			sel = xorshift();
			case (sel[1:0])
				2'd0: r = ins[25:21];
				2'd1: r = ins[20:16];
				2'd2: r = 5'd0;
				default: r = randReg();
			endcase
			stepCycle(ins, 1'b1, makeWb(1'b0, 5'd0), sel[2] | sel[3], r);
			if (loadUseStall(ins, sel[2] | sel[3], r)) begin
				stepCycle(ins, 1'b1, makeWb(1'b0, 5'd0), 1'b0, 5'd0); // Held, load gone.
			end
		end
		reportTest(5, "load-use stall", startErr);
		startErr = errCount;
		for (int k = 0; k < 6 && !timedOut; k++) begin
			r = randReg() | 5'd1;                   // Nonzero so the load hits.
			ins = rType(r, randReg(), randReg(), fnAnd);
			holdFor = 1 + int'(xorshift() % 3);
			seen = 0;
			stepCycle(ins, 1'b1, makeWb(1'b0, 5'd0), 1'b1, r);
			for (int n = 1; stall && n < 10; n++) begin
				stepCycle(ins, 1'b1, makeWb(1'b0, 5'd0), n < holdFor, r);
				if (idEx.valid) begin
					seen++;
				end
			end
			if (stall) begin
				timedOut = 1'b1;
				$display("stall stayed high for 10 cycles after the load left execute");
			end
			stepCycle(randomInstr(), 1'b0, makeWb(1'b0, 5'd0), 1'b0, 5'd0); // Empty slot.
			checkCount++;
			assert (seen == 1) else begin
				$display("held instruction reached ID/EX %0d times instead of once", seen);
				errCount++;
			end
		end
		reportTest(6, "upstream hold", startErr);
	endtask

	initial begin
		rngState   = 32'd6299;
		pcCount    = 32'h0000_0004;
		errCount   = 0;
		checkCount = 0;
		timedOut   = 1'b0;
		rstN       = 1'b0;
		instr      = '0;
		pcPlus4    = '0;
		ifValid    = 1'b0;
		wb         = '0;
		exMemRead  = 1'b0;
		exWriteReg = '0;
		clearShadow();
		repeat (5) @(negedge Clk);                  // Five cycles in reset.
		rstN = 1'b1;
		runTests();
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0 && !timedOut) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+.
idPkg.sv
regFile.sv
instrDecode.sv
hazardUnit.sv
idExReg.sv
idStage.sv
idStageTb.sv

// File: Bender.yml
package:
  name: idStage

sources:
  - idPkg.sv
  - regFile.sv
  - instrDecode.sv
  - hazardUnit.sv
  - idExReg.sv
  - idStage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - idStageTb.sv
